// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tcb_subsystem_tb
VFLAGS    ?= --binary --timing

FILELIST  := sim.f
DATA      := sim/tcb_testdata.txt
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a listed source, the file list or the data file changes
$(BIN): $(SOURCES) $(FILELIST) $(DATA)
	$(VERILATOR) $(VFLAGS) --Mdir obj_dir --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

# exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== hdl/tcb_memory.sv ====
////////////////////////////////////////
// word memory on the bus, one cycle response, address range error
// and a one cycle refresh stall every REFRESH_PERIOD cycles
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_memory import tcb_pkg::*; #(
    // number of words, must fit the word index of the address
    parameter int unsigned MEM_DEPTH      = 256,
    // cycles between refresh stalls, at least 2
    parameter int unsigned REFRESH_PERIOD = 13
) (
    input  logic sub,
    input  logic reset,
    // request
    input  logic vld,
    output logic rdy,
    input  logic wen,
    input  adr_t adr,
    input  byt_t byt,
    input  dat_t wdt,
    // response, one edge after the transfer
    output dat_t rdt,
    output logic err
);

    ////////////////////////////////////////
    // local widths and types
    ////////////////////////////////////////

    // word index is the byte address without the lane bits
    localparam int IDX_W = TCB_ADR - 2;
    // array index width
    localparam int MEM_AW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    // refresh counter width
    localparam int CNT_W = (REFRESH_PERIOD > 1) ? $clog2(REFRESH_PERIOD) : 1;
    // last count of a refresh period, the stall cycle
    localparam int unsigned CNT_LAST = REFRESH_PERIOD - 1;

    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [MEM_AW-1:0] mem_idx_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    // storage, no reset
    dat_t mem [MEM_DEPTH];

    logic     trn;
    idx_t     idx;
    mem_idx_t mem_idx;
    logic     in_range;
    cnt_t     ref_cnt;

    ////////////////////////////////////////
    // refresh
    ////////////////////////////////////////

    // free running period counter, restarts at reset
    always_ff @(posedge sub) begin
        if (reset) begin
            ref_cnt <= '0;
        end else if (32'(ref_cnt) == CNT_LAST) begin
            ref_cnt <= '0;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // refuse requests during the last cycle of each period
    assign rdy = (32'(ref_cnt) != CNT_LAST);

    assign trn = vld & rdy;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    assign idx = adr[TCB_ADR-1:2];

    // words past the depth answer with an error
    assign in_range = (32'(idx) < MEM_DEPTH);

    // low index bits select the word, high bits alias
    assign mem_idx = idx[MEM_AW-1:0];

    ////////////////////////////////////////
    // write
    ////////////////////////////////////////

    // byte lane write, out of range writes are dropped
    always_ff @(posedge sub) begin
        if (trn && wen && in_range) begin
            for (int i = 0; i < TCB_BYT; i++) begin
                if (byt[i]) begin
                    mem[mem_idx][i*8 +: 8] <= wdt[i*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////

    // response registers update only on a transfer and hold otherwise
    // a read returns the stored word, a write returns zero
    // an out of range address returns zero with err set
    always_ff @(posedge sub) begin
        if (reset) begin
            rdt <= '0;
            err <= 1'b0;
        end else if (trn) begin
            if (!in_range) begin
                rdt <= '0;
                err <= 1'b1;
            end else if (wen) begin
                rdt <= '0;
                err <= 1'b0;
            end else begin
                rdt <= mem[mem_idx];
                err <= 1'b0;
            end
        end
    end

endmodule : tcb_memory

// ==== hdl/tcb_pkg.sv ====
////////////////////////////////////////
// bus widths and vector types of the tightly coupled memory bus
// imported by every module and by the testbench
////////////////////////////////////////

package tcb_pkg;

    ////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////

    // data width in bits, one word per transfer
    localparam int TCB_DAT = 32;

    // number of byte lanes in a word
    localparam int TCB_BYT = TCB_DAT / 8;

    // byte address width
    localparam int TCB_ADR = 16;

    // response delay seen by the manager at the top level
    // one cycle in the request slice plus one in the memory
    localparam int TCB_DLY = 2;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    // byte address, the two low bits select a lane inside a word
    typedef logic [TCB_ADR-1:0] adr_t;

    // data word, used for both write and read data
    typedef logic [TCB_DAT-1:0] dat_t;

    // byte enable mask
    // bit i enables data bits 8i up to 8i+7
    typedef logic [TCB_BYT-1:0] byt_t;

endpackage : tcb_pkg

// ==== hdl/tcb_request_slice.sv ====
////////////////////////////////////////
// register stage on the bus request path, response path passes straight through
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_request_slice import tcb_pkg::*; (
    input  logic sub,
    input  logic reset,
    // up side, faces the manager
    input  logic up_vld,
    output logic up_rdy,
    input  logic up_wen,
    input  adr_t up_adr,
    input  byt_t up_byt,
    input  dat_t up_wdt,
    output dat_t up_rdt,
    output logic up_err,
    // dn side, faces the subordinate
    output logic dn_vld,
    input  logic dn_rdy,
    output logic dn_wen,
    output adr_t dn_adr,
    output byt_t dn_byt,
    output dat_t dn_wdt,
    input  dat_t dn_rdt,
    input  logic dn_err
);

    // transfer on the up side
    logic up_trn;

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////

    // ready while the register is empty or being drained
    // so an empty slot never stalls the manager
    assign up_rdy = dn_rdy | ~dn_vld;

    assign up_trn = up_vld & up_rdy;

    // valid register, a bubble on the up side clears the slot
    always_ff @(posedge sub) begin
        if (reset) begin
            dn_vld <= 1'b0;
        end else if (up_rdy) begin
            dn_vld <= up_vld;
        end
    end

    ////////////////////////////////////////
    // request payload
    ////////////////////////////////////////

    // control fields load on every up transfer
    always_ff @(posedge sub) begin
        if (up_trn) begin
            dn_wen <= up_wen;
            dn_adr <= up_adr;
            dn_byt <= up_byt;
        end
    end

    // write data loads lane by lane
    // only enabled lanes of a write toggle, the rest keep stale data
    // which the subordinate ignores through dn_byt
    for (genvar i = 0; i < TCB_BYT; i++) begin : gen_wdt
        always_ff @(posedge sub) begin
            if (up_trn && up_wen && up_byt[i]) begin
                dn_wdt[i*8 +: 8] <= up_wdt[i*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////

    // no register here, the response keeps the subordinate timing
    assign up_rdt = dn_rdt;
    assign up_err = dn_err;

endmodule : tcb_request_slice

// ==== hdl/tcb_subsystem.sv ====
////////////////////////////////////////
// memory subsystem top, request slice in front of a word memory
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_subsystem import tcb_pkg::*; #(
    parameter int unsigned MEM_DEPTH      = 256,
    parameter int unsigned REFRESH_PERIOD = 13
) (
    input  logic sub,
    input  logic reset,
    // request from the manager
    input  logic vld,
    output logic rdy,
    input  logic wen,
    input  adr_t adr,
    input  byt_t byt,
    input  dat_t wdt,
    // response, TCB_DLY edges after the transfer
    output dat_t rdt,
    output logic err
);

    ////////////////////////////////////////
    // slice to memory bus
    ////////////////////////////////////////

    logic dn_vld;
    logic dn_rdy;
    logic dn_wen;
    adr_t dn_adr;
    byt_t dn_byt;
    dat_t dn_wdt;
    dat_t dn_rdt;
    logic dn_err;

    // cuts the request path from the manager
    tcb_request_slice slice_i (
        .sub    (sub),
        .reset  (reset),
        .up_vld (vld),
        .up_rdy (rdy),
        .up_wen (wen),
        .up_adr (adr),
        .up_byt (byt),
        .up_wdt (wdt),
        .up_rdt (rdt),
        .up_err (err),
        .dn_vld (dn_vld),
        .dn_rdy (dn_rdy),
        .dn_wen (dn_wen),
        .dn_adr (dn_adr),
        .dn_byt (dn_byt),
        .dn_wdt (dn_wdt),
        .dn_rdt (dn_rdt),
        .dn_err (dn_err)
    );

    // storage, adds the second cycle of response delay
    tcb_memory #(
        .MEM_DEPTH      (MEM_DEPTH),
        .REFRESH_PERIOD (REFRESH_PERIOD)
    ) memory_i (
        .sub   (sub),
        .reset (reset),
        .vld   (dn_vld),
        .rdy   (dn_rdy),
        .wen   (dn_wen),
        .adr   (dn_adr),
        .byt   (dn_byt),
        .wdt   (dn_wdt),
        .rdt   (dn_rdt),
        .err   (dn_err)
    );

endmodule : tcb_subsystem

// ==== sim.f ====
hdl/tcb_pkg.sv
hdl/tcb_request_slice.sv
hdl/tcb_memory.sv
hdl/tcb_subsystem.sv
sim/tcb_subsystem_tb.sv

// ==== sim/tcb_subsystem_tb.sv ====
////////////////////////////////////////
// testbench for the memory subsystem that replays the request file
// and checks each response against a cycle model of slice and refresh
////////////////////////////////////////

`timescale 1ns/1ns

module tcb_subsystem_tb import tcb_pkg::*; ();

    localparam int unsigned MEM_DEPTH      = 256;
    localparam int unsigned REFRESH_PERIOD = 13;
    localparam int          RESET_CYCLES   = 16;
    // watchdog budget per data line
    localparam int          CYCLES_PER_REQ = 20;
    localparam string       DATA_FILE      = "sim/tcb_testdata.txt";

    // dut ports
    logic sub;
    logic reset;
    logic vld;
    logic rdy;
    logic wen;
    adr_t adr;
    byt_t byt;
    dat_t wdt;
    dat_t rdt;
    logic err;

    // requests and expected responses with one entry per data line
    logic q_wen [$];
    adr_t q_adr [$];
    byt_t q_byt [$];
    dat_t q_wdt [$];
    dat_t q_rdt [$];
    logic q_err [$];
    int   n_lines;
    logic load_done;

    // accepted requests awaiting a response with line, accept cycle and due cycle
    dat_t  pend_rdt [$];
    logic  pend_err [$];
    int    pend_line [$];
    int    pend_cyc [$];
    int    pend_due [$];
    string ctx;

    // cycle model of slice occupancy and refresh count
    int   cyc;
    int   mdl_cnt;
    logic mdl_full;
    int   n_checked;
    logic [31:0] rng;

    tcb_subsystem #(
        .MEM_DEPTH      (MEM_DEPTH),
        .REFRESH_PERIOD (REFRESH_PERIOD)
    ) dut_i (
        .sub   (sub),
        .reset (reset),
        .vld   (vld),
        .rdy   (rdy),
        .wen   (wen),
        .adr   (adr),
        .byt   (byt),
        .wdt   (wdt),
        .rdt   (rdt),
        .err   (err)
    );

    // 8 ns clock
    always #4 sub = ~sub;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic fail_now();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_rdt(input string name, input dat_t got, input dat_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h expected %h (%s)", $time, name, got, exp, ctx);
            fail_now();
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %b expected %b (%s)", $time, name, got, exp, ctx);
            fail_now();
        end
    endtask

    task automatic check_rdy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %b expected %b in cycle %0d", $time, name, got, exp, cyc);
            fail_now();
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // zero to three idle cycles with zero five times in eight so bursts stay long
    task automatic pick_idle(output int n);
        rng = xorshift32(rng);
        case (rng[2:0])
            3'd5:    n = 1;
            3'd6:    n = 2;
            3'd7:    n = 3;
            default: n = 0;
        endcase
    endtask

    // one clock cycle run after a falling edge once the inputs are driven
    // idx is the data line on offer or -1 while idle
    task automatic step(input int idx, output logic accepted);
        logic mem_rdy;
        logic up_rdy;
        // response registered by the memory on the last rising edge
        if (pend_due.size() > 0 && pend_due[0] == cyc) begin
            ctx = $sformatf("data line %0d, accepted in cycle %0d",
                            pend_line[0] + 1, pend_cyc[0]);
            check_rdt("rdt", rdt, pend_rdt[0]);
            check_err("err", err, pend_err[0]);
            n_checked++;
            pend_rdt.delete(0);
            pend_err.delete(0);
            pend_line.delete(0);
            pend_cyc.delete(0);
            pend_due.delete(0);
        end
        // memory refuses in the last cycle of each refresh period
        mem_rdy = (mdl_cnt != int'(REFRESH_PERIOD) - 1);
        // slice takes a request when empty or draining
        up_rdy = mem_rdy || !mdl_full;
        check_rdy("rdy", rdy, up_rdy);
        // a refresh stall keeps the request in the slice one more cycle
        // so its response moves back by the same amount
        if (mdl_full && !mem_rdy) begin
            pend_due[pend_due.size() - 1] = pend_due[pend_due.size() - 1] + 1;
        end
        accepted = vld && up_rdy;
        if (accepted) begin
            pend_rdt.push_back(q_rdt[idx]);
            pend_err.push_back(q_err[idx]);
            pend_line.push_back(idx);
            pend_cyc.push_back(cyc);
            pend_due.push_back(cyc + TCB_DLY);
        end
        // a bubble on the up side empties the slice
        if (up_rdy) begin
            mdl_full = vld;
        end
        mdl_cnt = (mdl_cnt == int'(REFRESH_PERIOD) - 1) ? 0 : mdl_cnt + 1;
        cyc++;
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin : main
        int          fd;
        int          code;
        int          fields;
        int          idle;
        logic        accepted;
        logic [31:0] f_wen;
        logic [31:0] f_adr;
        logic [31:0] f_byt;
        logic [31:0] f_wdt;
        logic [31:0] f_rdt;
        logic [31:0] f_err;
        string       text;

        sub       = 1'b0;
        reset     = 1'b1;
        vld       = 1'b0;
        wen       = 1'b0;
        adr       = '0;
        byt       = '0;
        wdt       = '0;
        load_done = 1'b0;
        n_lines   = 0;
        n_checked = 0;
        cyc       = 0;
        mdl_cnt   = 0;
        mdl_full  = 1'b0;
        rng       = 32'h5e626557;

        // columns are wen adr byt wdt rdt err in hex and // starts a comment line
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the data file %s", DATA_FILE);
            fail_now();
        end
        while (!$feof(fd)) begin
            text = "";
            code = $fgets(text, fd);
            if (code <= 0 || text.len() < 2 || text.substr(0, 1) == "//") begin
                continue;
            end
            fields = $sscanf(text, "%h %h %h %h %h %h",
                             f_wen, f_adr, f_byt, f_wdt, f_rdt, f_err);
            if (fields != 6 || f_wen > 1 || f_err > 1 ||
                (f_adr >> TCB_ADR) != 0 || (f_byt >> TCB_BYT) != 0) begin
                $display("malformed data line %0d: %s", n_lines + 1, text);
                fail_now();
            end
            q_wen.push_back(f_wen[0]);
            q_adr.push_back(adr_t'(f_adr));
            q_byt.push_back(byt_t'(f_byt));
            q_wdt.push_back(dat_t'(f_wdt));
            q_rdt.push_back(dat_t'(f_rdt));
            q_err.push_back(f_err[0]);
            n_lines++;
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("the data file %s holds no requests", DATA_FILE);
            fail_now();
        end
        load_done = 1'b1;

        // release reset on a falling edge where the refresh count starts at zero
        repeat (RESET_CYCLES) @(negedge sub);
        reset = 1'b0;
        ctx = "after reset";
        check_rdt("rdt", rdt, '0);
        check_err("err", err, 1'b0);
        step(-1, accepted);

        for (int n = 0; n < n_lines; n++) begin
            pick_idle(idle);
            repeat (idle) begin
                @(negedge sub);
                vld = 1'b0;
                step(-1, accepted);
            end
            // offer the request and hold it until the slice takes it
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge sub);
                vld = 1'b1;
                wen = q_wen[n];
                adr = q_adr[n];
                byt = q_byt[n];
                wdt = q_wdt[n];
                if (n == 0 && rdy !== 1'b1) begin
                    $display("the first request after reset was refused");
                    fail_now();
                end
                step(n, accepted);
            end
        end

        // drain the slice and the last response
        while (pend_due.size() > 0) begin
            @(negedge sub);
            vld = 1'b0;
            step(-1, accepted);
        end

        if (n_checked != n_lines) begin
            $display("%0d responses checked for %0d data lines", n_checked, n_lines);
            fail_now();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    // run limit scales with the number of data lines
    initial begin : watchdog
        wait (load_done === 1'b1);
        repeat (RESET_CYCLES + CYCLES_PER_REQ * n_lines) @(posedge sub);
        $display("the run did not finish within %0d cycles",
                 RESET_CYCLES + CYCLES_PER_REQ * n_lines);
        fail_now();
    end

endmodule : tcb_subsystem_tb

// ==== sim/tcb_testdata.txt ====
// columns: wen adr byt wdt rdt err, all hex, one request per line
// rdt and err are the expected response, writes answer with rdt zero
1 0000 f 0000ffff 00000000 0
1 0004 f 0004fffb 00000000 0
1 0008 f 0008fff7 00000000 0
1 000c f 000cfff3 00000000 0
1 0010 f 0010ffef 00000000 0
1 0014 f 0014ffeb 00000000 0
1 0018 f 0018ffe7 00000000 0
1 001c f 001cffe3 00000000 0
1 0020 f 0020ffdf 00000000 0
1 0024 f 0024ffdb 00000000 0
1 0028 f 0028ffd7 00000000 0
1 002c f 002cffd3 00000000 0
1 0030 f 0030ffcf 00000000 0
1 0034 f 0034ffcb 00000000 0
1 0038 f 0038ffc7 00000000 0
1 003c f 003cffc3 00000000 0
1 03fc f 03fcfc03 00000000 0
1 0200 f 0200fdff 00000000 0
// partial writes over the full words
1 0004 1 111111aa 00000000 0
1 0008 2 2222bb22 00000000 0
1 000c 4 33cc3333 00000000 0
1 0010 8 dd444444 00000000 0
1 0014 5 11223344 00000000 0
1 0018 a 55667788 00000000 0
1 001c 0 ffffffff 00000000 0
1 0020 6 99aabbcc 00000000 0
// writes beyond the depth, dropped
1 0400 f deadbeef 00000000 1
1 0404 f 12345678 00000000 1
1 8000 f cafef00d 00000000 1
1 fffc f 0badf00d 00000000 1
// read back, aliases keep their old words
0 0000 f 00000000 0000ffff 0
0 0004 f 00000000 0004ffaa 0
0 0008 f 00000000 0008bbf7 0
0 000c f 00000000 00ccfff3 0
0 0010 f 00000000 dd10ffef 0
0 0014 f 00000000 0022ff44 0
0 0018 f 00000000 551877e7 0
0 001c f 00000000 001cffe3 0
0 0020 f 00000000 00aabbdf 0
0 0024 f 00000000 0024ffdb 0
0 0028 f 00000000 0028ffd7 0
0 002c f 00000000 002cffd3 0
0 0030 f 00000000 0030ffcf 0
0 0034 f 00000000 0034ffcb 0
0 0038 f 00000000 0038ffc7 0
0 003c f 00000000 003cffc3 0
0 03fc f 00000000 03fcfc03 0
0 0200 f 00000000 0200fdff 0
// reads beyond the depth
0 0400 f 00000000 00000000 1
0 0800 f 00000000 00000000 1
0 fffc f 00000000 00000000 1
0 0401 f 00000000 00000000 1
// lane bits of the address are ignored
0 0003 f 00000000 0000ffff 0
0 0006 f 00000000 0004ffaa 0
// burst of writes then reads
1 0040 f 0040ffbf 00000000 0
1 0044 f 0044ffbb 00000000 0
1 0048 f 0048ffb7 00000000 0
1 004c f 004cffb3 00000000 0
1 0050 f 0050ffaf 00000000 0
1 0054 f 0054ffab 00000000 0
1 0058 f 0058ffa7 00000000 0
1 005c f 005cffa3 00000000 0
0 0040 f 00000000 0040ffbf 0
0 0044 f 00000000 0044ffbb 0
0 0048 f 00000000 0048ffb7 0
0 004c f 00000000 004cffb3 0
0 0050 f 00000000 0050ffaf 0
0 0054 f 00000000 0054ffab 0
0 0058 f 00000000 0058ffa7 0
0 005c f 00000000 005cffa3 0
1 0100 f 0100feff 00000000 0
0 0100 f 00000000 0100feff 0
1 0104 f 0104fefb 00000000 0
0 0104 f 00000000 0104fefb 0
1 0108 f 0108fef7 00000000 0
0 0108 f 00000000 0108fef7 0
1 0100 c 77770000 00000000 0
0 0100 f 00000000 7777feff 0
